/* icache_pkg.sv */
package icache_pkg;

    ////////////////////////////////////////
    // address and cache geometry
    ////////////////////////////////////////

    // fetch address and instruction word
    localparam int addr_w = 32;
    localparam int word_w = 32;

    // 16 sets, 4 words per line
    localparam int index_w  = 4;
    localparam int offset_w = 2;
    localparam int num_ways = 2;

    localparam int num_sets       = 2 ** index_w;
    localparam int words_per_line = 2 ** offset_w;

    // low 2 bits select a byte inside the word
    localparam int tag_w  = addr_w - index_w - offset_w - 2;
    localparam int line_w = word_w * words_per_line;

    ////////////////////////////////////////
    // control fsm states
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_lookup = 3'd1,
        st_miss   = 3'd2,
        st_wait   = 3'd3,
        st_flush  = 3'd4
    } fsm_state_t;

endpackage

/* icache_req_buf.sv */
module icache_req_buf (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           rbuf_we,
    input  logic [icache_pkg::addr_w-1:0]  addr,
    output logic [icache_pkg::addr_w-1:0]  lookup_addr
);

    // address fields of the request in lookup
    logic [icache_pkg::tag_w-1:0]    tag_q;
    logic [icache_pkg::index_w-1:0]  index_q;
    logic [icache_pkg::offset_w-1:0] offset_q;
    logic [1:0]                      byte_q;

    // held through lookup, miss and wait
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tag_q    <= '0;
            index_q  <= '0;
            offset_q <= '0;
            byte_q   <= '0;
        end else if (rbuf_we) begin
            tag_q    <= addr[icache_pkg::addr_w-1 -: icache_pkg::tag_w];
            index_q  <= addr[icache_pkg::offset_w+2 +: icache_pkg::index_w];
            offset_q <= addr[2 +: icache_pkg::offset_w];
            byte_q   <= addr[1:0];
        end
    end

    // fields back into one address for the downstream stages
    assign lookup_addr = {tag_q, index_q, offset_q, byte_q};

endmodule

/* icache_tagv_data.sv */
module icache_tagv_data (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [icache_pkg::addr_w-1:0]    lookup_addr,
    input  logic [icache_pkg::num_ways-1:0]  refill_we,
    input  logic [icache_pkg::line_w-1:0]    mem_line,
    output logic [icache_pkg::num_ways-1:0]  hit,
    output logic [icache_pkg::line_w-1:0]    way_line0,
    output logic [icache_pkg::line_w-1:0]    way_line1
);

    logic [icache_pkg::tag_w-1:0]   req_tag;
    logic [icache_pkg::index_w-1:0] req_index;

    // line read per way, combinational
    logic [icache_pkg::line_w-1:0]  rd_line [icache_pkg::num_ways];

    assign req_tag   = lookup_addr[icache_pkg::addr_w-1 -: icache_pkg::tag_w];
    assign req_index = lookup_addr[icache_pkg::offset_w+2 +: icache_pkg::index_w];

    ////////////////////////////////////////
    // one storage block per way
    ////////////////////////////////////////

    for (genvar w = 0; w < icache_pkg::num_ways; w++) begin : g_way
        logic [icache_pkg::num_sets-1:0] valid_q;
        logic [icache_pkg::tag_w-1:0]    tag_mem  [icache_pkg::num_sets];
        logic [icache_pkg::line_w-1:0]   line_mem [icache_pkg::num_sets];

        // all lines invalid out of reset
        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid_q <= '0;
            end else if (refill_we[w]) begin
                valid_q[req_index] <= 1'b1;
            end
        end

        // tag and line written together on refill
        always_ff @(posedge clk) begin
            if (refill_we[w]) begin
                tag_mem[req_index]  <= req_tag;
                line_mem[req_index] <= mem_line;
            end
        end

        assign hit[w]     = valid_q[req_index] && (tag_mem[req_index] == req_tag);
        assign rd_line[w] = line_mem[req_index];
    end

    assign way_line0 = rd_line[0];
    assign way_line1 = rd_line[1];

endmodule

/* icache_lru.sv */
module icache_lru (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [icache_pkg::addr_w-1:0]  lookup_addr,
    input  logic                           use_valid,
    input  logic                           use_way,
    output logic                           victim
);

    logic [icache_pkg::index_w-1:0]  set_index;

    // one bit per set, points at the way to replace next
    logic [icache_pkg::num_sets-1:0] lru_q;

    assign set_index = lookup_addr[icache_pkg::offset_w+2 +: icache_pkg::index_w];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (use_valid) begin
            // the way not just used becomes the victim
            lru_q[set_index] <= ~use_way;
        end
    end

    assign victim = lru_q[set_index];

endmodule

/* icache_fsm.sv */
module icache_fsm (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             valid,
    input  logic                             stall,
    input  logic                             flush,
    input  logic [icache_pkg::num_ways-1:0]  hit,
    input  logic                             victim,
    input  logic                             addr_ok,
    input  logic                             data_ok,
    output logic                             ready,
    output logic                             rbuf_we,
    output logic                             mem_req,
    output logic [icache_pkg::num_ways-1:0]  refill_we,
    output logic                             use_valid,
    output logic                             use_way,
    output logic                             choose_return,
    output logic                             out_we
);

    icache_pkg::fsm_state_t state_q;
    icache_pkg::fsm_state_t state_d;

    logic rstn_q;
    logic ready_int;
    logic accept;
    logic any_hit;

    ////////////////////////////////////////
    // registered reset for ready
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rstn_q <= 1'b0;
        end else begin
            rstn_q <= 1'b1;
        end
    end

    assign ready   = ready_int & rstn_q;
    assign accept  = valid & ready;
    assign any_hit = |hit;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= icache_pkg::st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////
    // next state and control outputs
    ////////////////////////////////////////

    always_comb begin
        state_d       = state_q;
        ready_int     = 1'b0;
        rbuf_we       = 1'b0;
        mem_req       = 1'b0;
        refill_we     = '0;
        use_valid     = 1'b0;
        use_way       = 1'b0;
        choose_return = 1'b0;
        out_we        = 1'b0;

        case (state_q)
            icache_pkg::st_idle: begin
                // stall keeps new requests out
                ready_int = ~stall;
                if (accept) begin
                    rbuf_we = 1'b1;
                    state_d = icache_pkg::st_lookup;
                end
            end

            icache_pkg::st_lookup: begin
                if (flush) begin
                    // request dropped, no refill and no result
                    state_d = icache_pkg::st_flush;
                end else if (!any_hit) begin
                    state_d = icache_pkg::st_miss;
                end else if (!stall) begin
                    ready_int = 1'b1;
                    out_we    = 1'b1;
                    use_valid = 1'b1;
                    use_way   = hit[1];
                    if (accept) begin
                        rbuf_we = 1'b1;
                        state_d = icache_pkg::st_lookup;
                    end else begin
                        state_d = icache_pkg::st_idle;
                    end
                end
                // hit under stall stays in lookup
            end

            icache_pkg::st_miss: begin
                // address held until the memory takes it
                mem_req = 1'b1;
                if (addr_ok) begin
                    state_d = icache_pkg::st_wait;
                end
            end

            icache_pkg::st_wait: begin
                if (data_ok) begin
                    refill_we[victim] = 1'b1;
                    use_valid         = 1'b1;
                    use_way           = victim;
                    choose_return     = 1'b1;
                    out_we            = 1'b1;
                    ready_int         = ~stall;
                    if (accept) begin
                        rbuf_we = 1'b1;
                        state_d = icache_pkg::st_lookup;
                    end else begin
                        state_d = icache_pkg::st_idle;
                    end
                end
            end

            icache_pkg::st_flush: begin
                if (!flush) begin
                    state_d = icache_pkg::st_idle;
                end
            end

            default: begin
                state_d = icache_pkg::st_idle;
            end
        endcase
    end

endmodule

/* icache_out_stage.sv */
module icache_out_stage (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             out_we,
    input  logic                             choose_return,
    input  logic [icache_pkg::num_ways-1:0]  hit,
    input  logic [icache_pkg::addr_w-1:0]    lookup_addr,
    input  logic [icache_pkg::line_w-1:0]    way_line0,
    input  logic [icache_pkg::line_w-1:0]    way_line1,
    input  logic [icache_pkg::line_w-1:0]    mem_line,
    output logic                             inst_valid,
    output logic [icache_pkg::addr_w-1:0]    inst_addr,
    output logic [icache_pkg::word_w-1:0]    inst
);

    logic [icache_pkg::line_w-1:0]   sel_line;
    logic [icache_pkg::word_w-1:0]   sel_word;
    logic [icache_pkg::offset_w-1:0] word_offset;

    assign word_offset = lookup_addr[2 +: icache_pkg::offset_w];

    // refill data is forwarded, it is not in the arrays yet
    assign sel_line = choose_return ? mem_line :
                      hit[1]        ? way_line1 : way_line0;

    always_comb begin
        sel_word = '0;
        for (int i = 0; i < icache_pkg::words_per_line; i++) begin
            if (word_offset == i) begin
                sel_word = sel_line[i*icache_pkg::word_w +: icache_pkg::word_w];
            end
        end
    end

    // result pulse, one cycle after out_we
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= out_we;
        end
    end

    always_ff @(posedge clk) begin
        if (out_we) begin
            inst      <= sel_word;
            inst_addr <= lookup_addr;
        end
    end

endmodule

/* icache_top.sv */
module icache_top (
    input  logic                           clk,
    input  logic                           rstn,
    // fetch side
    input  logic                           valid,
    input  logic [icache_pkg::addr_w-1:0]  addr,
    input  logic                           stall,
    input  logic                           flush,
    output logic                           ready,
    output logic                           inst_valid,
    output logic [icache_pkg::addr_w-1:0]  inst_addr,
    output logic [icache_pkg::word_w-1:0]  inst,
    // memory side
    output logic                           mem_req,
    output logic [icache_pkg::addr_w-1:0]  mem_addr,
    input  logic                           addr_ok,
    input  logic                           data_ok,
    input  logic [icache_pkg::line_w-1:0]  mem_line
);

    logic                             rbuf_we;
    logic [icache_pkg::addr_w-1:0]    lookup_addr;
    logic [icache_pkg::num_ways-1:0]  hit;
    logic [icache_pkg::line_w-1:0]    way_line0;
    logic [icache_pkg::line_w-1:0]    way_line1;
    logic                             victim;
    logic [icache_pkg::num_ways-1:0]  refill_we;
    logic                             use_valid;
    logic                             use_way;
    logic                             choose_return;
    logic                             out_we;

    // line aligned, word and byte bits cleared
    assign mem_addr = {lookup_addr[icache_pkg::addr_w-1:icache_pkg::offset_w+2],
                       {(icache_pkg::offset_w+2){1'b0}}};

    icache_req_buf u_icache_req_buf (
        .clk         (clk),
        .rstn        (rstn),
        .rbuf_we     (rbuf_we),
        .addr        (addr),
        .lookup_addr (lookup_addr)
    );

    icache_tagv_data u_icache_tagv_data (
        .clk         (clk),
        .rstn        (rstn),
        .lookup_addr (lookup_addr),
        .refill_we   (refill_we),
        .mem_line    (mem_line),
        .hit         (hit),
        .way_line0   (way_line0),
        .way_line1   (way_line1)
    );

    icache_lru u_icache_lru (
        .clk         (clk),
        .rstn        (rstn),
        .lookup_addr (lookup_addr),
        .use_valid   (use_valid),
        .use_way     (use_way),
        .victim      (victim)
    );

    icache_fsm u_icache_fsm (
        .clk           (clk),
        .rstn          (rstn),
        .valid         (valid),
        .stall         (stall),
        .flush         (flush),
        .hit           (hit),
        .victim        (victim),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .ready         (ready),
        .rbuf_we       (rbuf_we),
        .mem_req       (mem_req),
        .refill_we     (refill_we),
        .use_valid     (use_valid),
        .use_way       (use_way),
        .choose_return (choose_return),
        .out_we        (out_we)
    );

    icache_out_stage u_icache_out_stage (
        .clk           (clk),
        .rstn          (rstn),
        .out_we        (out_we),
        .choose_return (choose_return),
        .hit           (hit),
        .lookup_addr   (lookup_addr),
        .way_line0     (way_line0),
        .way_line1     (way_line1),
        .mem_line      (mem_line),
        .inst_valid    (inst_valid),
        .inst_addr     (inst_addr),
        .inst          (inst)
    );

endmodule

/* tb_icache.sv */
module tb_icache;

    localparam int          drain_limit = 400;
    localparam logic [31:0] seed        = 32'he568ee2e;

    // 3 tags over 4 sets, so one set sees 3 lines compete for 2 ways
    localparam logic [icache_pkg::tag_w-1:0]   tag_pool [3] = '{24'h000040, 24'h5a1230, 24'hc30e07};
    localparam logic [icache_pkg::index_w-1:0] set_pool [4] = '{4'd1, 4'd6, 4'd9, 4'd14};

    logic                            clk;
    logic                            rstn;
    logic                            valid;
    logic [icache_pkg::addr_w-1:0]   addr;
    logic                            stall;
    logic                            flush;
    logic                            ready;
    logic                            inst_valid;
    logic [icache_pkg::addr_w-1:0]   inst_addr;
    logic [icache_pkg::word_w-1:0]   inst;
    logic                            mem_req;
    logic [icache_pkg::addr_w-1:0]   mem_addr;
    logic                            addr_ok;
    logic                            data_ok;
    logic [icache_pkg::line_w-1:0]   mem_line;

    typedef struct packed {
        logic [icache_pkg::addr_w-1:0] addr;
        logic                          miss;
        int                            acc;
        int                            lat;
    } pend_t;

    pend_t                        pend_q[$];
    logic [31:0]                  drv_seed = seed;
    logic [31:0]                  mem_seed = seed ^ 32'h0f0f0f0f;
    logic [icache_pkg::tag_w-1:0] ref_tag [icache_pkg::num_sets][2];
    logic [1:0]                   ref_valid [icache_pkg::num_sets];
    logic                         ref_lru [icache_pkg::num_sets];
    logic [31:0]                  lk_addr;
    logic [31:0]                  req_addr;
    logic                         in_lookup;
    logic                         held_hit;
    logic                         last_accept;
    logic                         timed_out;
    int                           cyc;
    int                           errors;
    int                           tests;
    int                           accepted;
    int                           results;
    int                           cancels;
    int                           hs_count;
    int                           hs_mark;
    int                           lk_acc;
    int                           lk_cycles;
    int                           mm_state;
    int                           mm_delay;

    icache_pkg::fsm_state_t dut_state;
    assign dut_state = u_icache_top.u_icache_fsm.state_q;

    icache_top u_icache_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(inout logic [31:0] s);
        s = s * 32'd1664525 + 32'd1013904223;
        return s;
    endfunction

    function automatic logic chance(input int pct);
        return ((lcg_next(drv_seed) >> 16) % 100) < pct;
    endfunction

    function automatic logic [31:0] pick_addr(input int tag_span);
        logic [31:0] r;
        r = lcg_next(drv_seed);
        return {tag_pool[(r >> 24) % tag_span], set_pool[r[23:22]], r[21:20], 2'b00};
    endfunction

    // memory contents as a scramble of the line address and the word index
    function automatic logic [31:0] line_word(input logic [31:0] a, input int w);
        logic [31:0] x;
        x = {a[31:4], 4'b0000} ^ (32'h9e3779b9 * (w + 1));
        x = x ^ (x >> 13);
        x = x * 32'h85ebca6b;
        return x ^ (x >> 16);
    endfunction

    ////////////////////////////////////////
    // reference 2-way lru model
    ////////////////////////////////////////

    // index is bits 7:4, tag is bits 31:8
    function automatic int model_probe(input logic [31:0] a);
        int way;
        way = -1;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[a[7:4]][w] && ref_tag[a[7:4]][w] == a[31:8]) begin
                way = w;
            end
        end
        return way;
    endfunction

    task automatic model_update(input logic [31:0] a);
        int way;
        way = model_probe(a);
        if (way < 0) begin
            way = int'(ref_lru[a[7:4]]);
            ref_valid[a[7:4]][way] = 1'b1;
            ref_tag[a[7:4]][way]   = a[31:8];
        end
        ref_lru[a[7:4]] = (way == 0);
    endtask

    task automatic check_word(input string name, input logic [icache_pkg::word_w-1:0] got,
                              input logic [icache_pkg::word_w-1:0] exp);
        if (got !== exp) begin
            $display("** Error @ %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [icache_pkg::addr_w-1:0] got,
                              input logic [icache_pkg::addr_w-1:0] exp);
        if (got !== exp) begin
            $display("** Error @ %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error @ %0t: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // memory model sampled at negedge
    ////////////////////////////////////////

    initial begin : memory_model
        logic                          nxt_addr_ok;
        logic                          nxt_data_ok;
        logic [icache_pkg::line_w-1:0] nxt_line;
        addr_ok  = 1'b0;
        data_ok  = 1'b0;
        mem_line = '0;
        nxt_line = '0;
        mm_state = 0;
        forever begin
            @(negedge clk);
            nxt_addr_ok = 1'b0;
            nxt_data_ok = 1'b0;
            if (mm_state == 0 && mem_req) begin
                mm_delay = (lcg_next(mem_seed) >> 16) % 4;
                req_addr = {lk_addr[31:4], 4'b0000};
                mm_state = 1;
            end
            if (mm_state == 1) begin
                check_addr("mem_addr", mem_addr, req_addr);
                if (!mem_req) begin
                    $display("mem_req dropped before addr_ok at %0t", $time);
                    errors++;
                end
                if (addr_ok) begin
                    mm_delay = 1 + (lcg_next(mem_seed) >> 16) % 5;
                    mm_state = 2;
                end else if (mm_delay == 0) begin
                    nxt_addr_ok = 1'b1;
                end else begin
                    mm_delay--;
                end
            end
            if (mm_state == 2) begin
                if (data_ok) begin
                    mm_state = 0;
                end else if (mm_delay == 1) begin
                    nxt_data_ok = 1'b1;
                    for (int w = 0; w < 4; w++) begin
                        nxt_line[w*32 +: 32] = line_word(req_addr, w);
                    end
                end else begin
                    mm_delay--;
                end
            end
            @(posedge clk);
            addr_ok  <= nxt_addr_ok;
            data_ok  <= nxt_data_ok;
            mem_line <= nxt_line;
        end
    end

    // request tracking and result checks
    always @(negedge clk) begin : monitor
        pend_t e;
        int    way;
        if (rstn) begin
            cyc++;
            if (mem_req && addr_ok) begin
                hs_count++;
            end
            if (stall && ready) begin
                $display("ready high while stall is high at %0t", $time);
                errors++;
            end
            if (held_hit && inst_valid) begin
                $display("hit result came out of a stalled lookup at %0t", $time);
                errors++;
            end
            if (inst_valid) begin
                if (pend_q.size() == 0) begin
                    $display("result with no request outstanding at %0t", $time);
                    errors++;
                end else begin
                    e = pend_q.pop_front();
                    results++;
                    check_addr("inst_addr", inst_addr, e.addr);
                    check_word("inst", inst, line_word(e.addr, int'(e.addr[3:2])));
                    check_count("memory handshakes", hs_count - hs_mark, int'(e.miss));
                    if (!e.miss) begin
                        check_count("hit latency", cyc - e.acc, e.lat);
                    end
                end
                hs_mark = hs_count;
            end
            held_hit = 1'b0;
            if (in_lookup) begin
                lk_cycles++;
                way = model_probe(lk_addr);
                if (flush) begin
                    cancels++;
                    in_lookup = 1'b0;
                end else if (way >= 0 && stall) begin
                    held_hit = 1'b1;
                end else begin
                    // a hit frees the lookup stage in the same cycle
                    if (way >= 0 && !ready) begin
                        $display("ready low during a lookup hit at %0t", $time);
                        errors++;
                    end
                    e.addr = lk_addr;
                    e.miss = (way < 0);
                    e.acc  = lk_acc;
                    e.lat  = lk_cycles + 1;
                    pend_q.push_back(e);
                    model_update(lk_addr);
                    in_lookup = 1'b0;
                end
            end
            // accepted now and in lookup next cycle
            last_accept = valid && ready;
            if (last_accept) begin
                accepted++;
                lk_addr   = addr;
                lk_acc    = cyc;
                lk_cycles = 0;
                in_lookup = 1'b1;
            end
        end
    end

    task automatic run_phase(input string name, input int cycles, input int valid_pct,
                             input int stall_pct, input int flush_pct, input int tag_span);
        int err_start;
        int waited;
        err_start = errors;
        accepted  = 0;
        results   = 0;
        cancels   = 0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            // hold a request until it is taken
            if (!valid || last_accept) begin
                valid <= chance(valid_pct);
                addr  <= pick_addr(tag_span);
            end
            stall <= chance(stall_pct);
            flush <= chance(flush_pct);
        end
        @(posedge clk);
        valid <= 1'b0;
        stall <= 1'b0;
        flush <= 1'b0;
        for (waited = 0; waited < drain_limit; waited++) begin
            if (pend_q.size() == 0 && !in_lookup && mm_state == 0) begin
                break;
            end
            @(posedge clk);
        end
        if (waited == drain_limit) begin
            timed_out = 1'b1;
            $display("timeout in %s, requests still in flight, fsm in %s",
                     name, dut_state.name());
        end
        if (accepted == 0) begin
            $display("no request was accepted in %s", name);
            errors++;
        end
        check_count("results plus flushed", results + cancels, accepted);
        tests++;
        $display("test %s: accepted %0d, results %0d, flushed %0d, errors %0d",
                 name, accepted, results, cancels, errors - err_start);
    endtask

    initial begin
        rstn        = 1'b0;
        valid       = 1'b0;
        addr        = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        in_lookup   = 1'b0;
        held_hit    = 1'b0;
        last_accept = 1'b0;
        timed_out   = 1'b0;
        for (int s = 0; s < icache_pkg::num_sets; s++) begin
            ref_valid[s] = 2'b00;
            ref_lru[s]   = 1'b0;
        end
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        run_phase("refill and evict", 300, 70, 0, 0, 3);
        if (!timed_out) begin
            run_phase("back-to-back hits", 200, 100, 0, 0, 2);
        end
        if (!timed_out) begin
            run_phase("stall", 300, 80, 30, 0, 3);
        end
        if (!timed_out) begin
            run_phase("flush", 300, 80, 15, 20, 3);
        end
        $display("tests %0d, cycles %0d, memory handshakes %0d, errors %0d",
                 tests, cyc, hs_count, errors);
        if (timed_out || errors != 0) begin
            $display("Result: FAILED");
        end else begin
            $display("Result: PASSED");
        end
        $finish;
    end

endmodule

/* icache_top.f */
icache_pkg.sv
icache_req_buf.sv
icache_tagv_data.sv
icache_lru.sv
icache_fsm.sv
icache_out_stage.sv
icache_top.sv
tb_icache.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_icache
FILELIST := icache_top.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
